//--- common/board_consts.svh
`ifndef BOARD_CONSTS_SVH
`define BOARD_CONSTS_SVH

// register bus
`define AXI_ADDR_W 5
`define AXI_DATA_W 32

// byte offsets of the register map
`define REG_CTRL 5'h00
`define REG_LEDS 5'h04
`define REG_HEX  5'h08
`define REG_LCD  5'h0C
`define REG_KEY  5'h10

// clocks of ps2_clock high before a partial frame is dropped
`define PS2_IDLE_CYCLES 2000

// lcd bus timing, in clock cycles
`define LCD_SETUP_CYCLES 4
`define LCD_EN_CYCLES    12
`define LCD_HOLD_CYCLES  6

`endif

//--- common/board_pkg.sv
package board_pkg;

	// keyboard receiver
	typedef enum logic [1:0] {
		PS2_IDLE,
		PS2_SHIFT,
		PS2_CHECK
	} ps2_state_e;

	// lcd write sequencer
	typedef enum logic [1:0] {
		LCD_IDLE,
		LCD_SETUP,
		LCD_STROBE,
		LCD_HOLD
	} lcd_state_e;

	// write and read channels of the register slave
	typedef enum logic {
		WR_IDLE,
		WR_RESP
	} axi_wr_state_e;

	typedef enum logic {
		RD_IDLE,
		RD_DATA
	} axi_rd_state_e;

	// AXI response codes, only the two this slave gives
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axi_resp_e;

endpackage

//--- ps2/ps2_receiver.sv
`include "board_consts.svh"

module ps2_receiver (
	input  logic       clock,
	input  logic       rst_n,
	input  logic       ps2_clock,
	input  logic       ps2_data,
	output logic [7:0] key_code,
	output logic       key_valid,
	output logic       frame_error
);
	import board_pkg::*;

	localparam int IDLE_W = $clog2(`PS2_IDLE_CYCLES + 1);

	logic [1:0]        clock_sync;
	logic [1:0]        data_sync;
	logic              clock_prev;
	logic              fall;
	ps2_state_e        state;
	logic [10:0]       frame;
	logic [3:0]        bit_count;
	logic [IDLE_W-1:0] idle_count;
	logic              frame_ok;

	// both lines idle high, so the synchronizers reset to one
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			clock_sync <= 2'b11;
			data_sync <= 2'b11;
			clock_prev <= 1'b1;
		end else begin
			clock_sync <= {clock_sync[0], ps2_clock};
			data_sync <= {data_sync[0], ps2_data};
			clock_prev <= clock_sync[1];
		end
	end

	assign fall = clock_prev & ~clock_sync[1];

	// bits arrive lsb first, so shift in from the top
	always_ff @(posedge clock) begin
		if (fall) begin
			frame <= {data_sync[1], frame[10:1]};
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= PS2_IDLE;
			bit_count <= '0;
			idle_count <= '0;
		end else begin
			case (state)
				PS2_IDLE: begin
					idle_count <= '0;
					if (fall) begin
						bit_count <= 4'd1;
						state <= PS2_SHIFT;
					end
				end
				PS2_SHIFT: begin
					if (fall) begin
						idle_count <= '0;
						bit_count <= bit_count + 4'd1;
						// start bit was edge one, stop bit is edge eleven
						if (bit_count == 4'd10) begin
							state <= PS2_CHECK;
						end
					end else if (clock_sync[1]) begin
						if (idle_count == IDLE_W'(`PS2_IDLE_CYCLES - 1)) begin
							state <= PS2_IDLE;
						end else begin
							idle_count <= idle_count + IDLE_W'(1);
						end
					end else begin
						idle_count <= '0;
					end
				end
				PS2_CHECK: begin
					state <= PS2_IDLE;
				end
				default: begin
					state <= PS2_IDLE;
				end
			endcase
		end
	end

	// start low, stop high, odd parity over data and parity bit
	assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);

	assign key_code = frame[8:1];
	assign key_valid = (state == PS2_CHECK) & frame_ok;
	assign frame_error = (state == PS2_CHECK) & ~frame_ok;

	// one result per frame, one cycle long
	assert property (@(posedge clock) disable iff (!rst_n)
		!(key_valid && frame_error));
	assert property (@(posedge clock) disable iff (!rst_n)
		(key_valid || frame_error) |=> !(key_valid || frame_error));

endmodule

//--- lcd/lcd_writer.sv
`include "board_consts.svh"

module lcd_writer (
	input  logic       clock,
	input  logic       rst_n,
	input  logic       lcd_req,
	input  logic [7:0] lcd_byte,
	input  logic       lcd_rs_in,
	output logic       lcd_busy,
	output logic [7:0] lcd_data,
	output logic       lcd_rs,
	output logic       lcd_rw,
	output logic       lcd_en
);
	import board_pkg::*;

	// wide enough for any of the three phases
	localparam int CNT_W = $clog2(`LCD_SETUP_CYCLES + `LCD_EN_CYCLES + `LCD_HOLD_CYCLES);

	lcd_state_e       state;
	logic [CNT_W-1:0] count;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= LCD_IDLE;
			count <= '0;
			lcd_en <= 1'b0;
		end else begin
			case (state)
				LCD_IDLE: begin
					if (lcd_req) begin
						state <= LCD_SETUP;
						count <= CNT_W'(`LCD_SETUP_CYCLES - 1);
					end
				end
				LCD_SETUP: begin
					if (count == '0) begin
						state <= LCD_STROBE;
						count <= CNT_W'(`LCD_EN_CYCLES - 1);
						lcd_en <= 1'b1;
					end else begin
						count <= count - CNT_W'(1);
					end
				end
				LCD_STROBE: begin
					// controller latches the byte on this falling edge
					if (count == '0) begin
						state <= LCD_HOLD;
						count <= CNT_W'(`LCD_HOLD_CYCLES - 1);
						lcd_en <= 1'b0;
					end else begin
						count <= count - CNT_W'(1);
					end
				end
				LCD_HOLD: begin
					if (count == '0) begin
						state <= LCD_IDLE;
					end else begin
						count <= count - CNT_W'(1);
					end
				end
				default: begin
					state <= LCD_IDLE;
					lcd_en <= 1'b0;
				end
			endcase
		end
	end

	// request byte and rs held from setup through hold
	always_ff @(posedge clock) begin
		if (lcd_req && state == LCD_IDLE) begin
			lcd_data <= lcd_byte;
			lcd_rs <= lcd_rs_in;
		end
	end

	assign lcd_busy = (state != LCD_IDLE);

	// write only
	assign lcd_rw = 1'b0;

	assert property (@(posedge clock) disable iff (!rst_n)
		(lcd_en && $past(lcd_en)) |-> ($stable(lcd_data) && $stable(lcd_rs)));

	// the register block only asks when idle
	assert property (@(posedge clock) disable iff (!rst_n)
		lcd_req |-> !lcd_busy);

endmodule

//--- verilog/hex_display.sv
module hex_display (
	input  logic [31:0] hex_value,
	output logic [6:0]  seg1,
	output logic [6:0]  seg2,
	output logic [6:0]  seg3,
	output logic [6:0]  seg4,
	output logic [6:0]  seg5,
	output logic [6:0]  seg6,
	output logic [6:0]  seg7,
	output logic [6:0]  seg8
);

	// active low, bit0 is segment a, bit6 is segment g
	function automatic logic [6:0] seg_font(input logic [3:0] nibble);
		case (nibble)
			4'h0: seg_font = 7'h40;
			4'h1: seg_font = 7'h79;
			4'h2: seg_font = 7'h24;
			4'h3: seg_font = 7'h30;
			4'h4: seg_font = 7'h19;
			4'h5: seg_font = 7'h12;
			4'h6: seg_font = 7'h02;
			4'h7: seg_font = 7'h78;
			4'h8: seg_font = 7'h00;
			4'h9: seg_font = 7'h10;
			4'hA: seg_font = 7'h08;
			4'hB: seg_font = 7'h03;
			4'hC: seg_font = 7'h46;
			4'hD: seg_font = 7'h21;
			4'hE: seg_font = 7'h06;
			default: seg_font = 7'h0E;
		endcase
	endfunction

	// digit 1 is the lowest nibble
	assign seg1 = seg_font(hex_value[3:0]);
	assign seg2 = seg_font(hex_value[7:4]);
	assign seg3 = seg_font(hex_value[11:8]);
	assign seg4 = seg_font(hex_value[15:12]);
	assign seg5 = seg_font(hex_value[19:16]);
	assign seg6 = seg_font(hex_value[23:20]);
	assign seg7 = seg_font(hex_value[27:24]);
	assign seg8 = seg_font(hex_value[31:28]);

endmodule

//--- verilog/board_regs.sv
`include "board_consts.svh"

module board_regs (
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic [`AXI_ADDR_W-1:0]    awaddr,
	input  logic                      awvalid,
	output logic                      awready,
	input  logic [`AXI_DATA_W-1:0]    wdata,
	input  logic [`AXI_DATA_W/8-1:0]  wstrb,
	input  logic                      wvalid,
	output logic                      wready,
	output board_pkg::axi_resp_e      bresp,
	output logic                      bvalid,
	input  logic                      bready,
	input  logic [`AXI_ADDR_W-1:0]    araddr,
	input  logic                      arvalid,
	output logic                      arready,
	output logic [`AXI_DATA_W-1:0]    rdata,
	output board_pkg::axi_resp_e      rresp,
	output logic                      rvalid,
	input  logic                      rready,
	input  logic [7:0]                key_code,
	input  logic                      key_valid,
	input  logic                      frame_error,
	input  logic                      lcd_busy,
	output logic                      lcd_req,
	output logic [7:0]                lcd_byte,
	output logic                      lcd_rs_in,
	output logic                      lcd_on,
	output logic                      lcd_blon,
	output logic [7:0]                leds,
	output logic [31:0]               hex_value
);
	import board_pkg::*;

	axi_wr_state_e wr_state;
	axi_rd_state_e rd_state;
	logic          wr_accept;
	logic          rd_accept;
	logic          key_clear;
	logic [2:0]    ctrl_reg;
	logic [7:0]    leds_reg;
	logic [31:0]   hex_reg;
	logic [7:0]    key_code_reg;
	logic          key_new;
	logic          key_overrun;
	logic          key_ferr;
	logic [`AXI_DATA_W-1:0] rd_mux;
	axi_resp_e     rd_resp_mux;

	// address and data are taken together, one write in flight
	assign awready = (wr_state == WR_IDLE);
	assign wready = (wr_state == WR_IDLE);
	assign wr_accept = awready & awvalid & wvalid;
	assign bvalid = (wr_state == WR_RESP);

	assign arready = (rd_state == RD_IDLE);
	assign rd_accept = arready & arvalid;
	assign rvalid = (rd_state == RD_DATA);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wr_state <= WR_IDLE;
			bresp <= OKAY;
			ctrl_reg <= '0;
			leds_reg <= '0;
			hex_reg <= '0;
		end else if (wr_state == WR_IDLE) begin
			if (wr_accept) begin
				wr_state <= WR_RESP;
				bresp <= OKAY;
				case (awaddr)
					`REG_CTRL: ctrl_reg <= wdata[2:0];
					`REG_LEDS: leds_reg <= wdata[7:0];
					`REG_HEX: hex_reg <= wdata;
					`REG_LCD: begin
						if (lcd_busy) begin
							bresp <= SLVERR;
						end
					end
					default: bresp <= SLVERR;
				endcase
			end
		end else if (bready) begin
			wr_state <= WR_IDLE;
		end
	end

	// combinational so the sequencer starts the cycle after accept
	assign lcd_req = wr_accept & (awaddr == `REG_LCD) & ~lcd_busy;
	assign lcd_byte = wdata[7:0];
	assign lcd_rs_in = wdata[8];

	// key status, a new event beats the read clear
	assign key_clear = rd_accept & (araddr == `REG_KEY);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			key_code_reg <= '0;
			key_new <= 1'b0;
			key_overrun <= 1'b0;
			key_ferr <= 1'b0;
		end else begin
			if (key_valid) begin
				key_code_reg <= key_code;
			end
			key_new <= key_valid | (key_new & ~key_clear);
			key_overrun <= (key_valid & key_new & ~key_clear) | (key_overrun & ~key_clear);
			key_ferr <= frame_error | (key_ferr & ~key_clear);
		end
	end

	always_comb begin
		rd_mux = '0;
		rd_resp_mux = OKAY;
		case (araddr)
			`REG_CTRL: rd_mux = {29'b0, ctrl_reg};
			`REG_LEDS: rd_mux = {24'b0, leds_reg};
			`REG_HEX: rd_mux = hex_reg;
			`REG_LCD: rd_mux = {31'b0, lcd_busy};
			`REG_KEY: rd_mux = {21'b0, key_ferr, key_overrun, key_new, key_code_reg};
			default: rd_resp_mux = SLVERR;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rd_state <= RD_IDLE;
			rresp <= OKAY;
		end else if (rd_state == RD_IDLE) begin
			if (rd_accept) begin
				rd_state <= RD_DATA;
				rresp <= rd_resp_mux;
			end
		end else if (rready) begin
			rd_state <= RD_IDLE;
		end
	end

	always_ff @(posedge clock) begin
		if (rd_accept) begin
			rdata <= rd_mux;
		end
	end

	assign lcd_on = ctrl_reg[0];
	assign lcd_blon = ctrl_reg[1];
	assign leds = leds_reg;
	// bit2 puts the last scancode on digits 1 and 2
	assign hex_value = ctrl_reg[2] ? {hex_reg[31:8], key_code_reg} : hex_reg;

	assert property (@(posedge clock) disable iff (!rst_n)
		(bvalid && !bready) |=> (bvalid && $stable(bresp)));
	assert property (@(posedge clock) disable iff (!rst_n)
		(rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)));

endmodule

//--- verilog/board_top.sv
`include "board_consts.svh"

module board_top (
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic [`AXI_ADDR_W-1:0]    awaddr,
	input  logic                      awvalid,
	output logic                      awready,
	input  logic [`AXI_DATA_W-1:0]    wdata,
	input  logic [`AXI_DATA_W/8-1:0]  wstrb,
	input  logic                      wvalid,
	output logic                      wready,
	output logic [1:0]                bresp,
	output logic                      bvalid,
	input  logic                      bready,
	input  logic [`AXI_ADDR_W-1:0]    araddr,
	input  logic                      arvalid,
	output logic                      arready,
	output logic [`AXI_DATA_W-1:0]    rdata,
	output logic [1:0]                rresp,
	output logic                      rvalid,
	input  logic                      rready,
	input  logic                      ps2_clock,
	input  logic                      ps2_data,
	output logic [7:0]                leds,
	output logic [7:0]                lcd_data,
	output logic                      lcd_rw,
	output logic                      lcd_en,
	output logic                      lcd_rs,
	output logic                      lcd_on,
	output logic                      lcd_blon,
	output logic [6:0]                seg1,
	output logic [6:0]                seg2,
	output logic [6:0]                seg3,
	output logic [6:0]                seg4,
	output logic [6:0]                seg5,
	output logic [6:0]                seg6,
	output logic [6:0]                seg7,
	output logic [6:0]                seg8
);

	logic [7:0]  key_code;
	logic        key_valid;
	logic        frame_error;
	logic        lcd_busy;
	logic        lcd_req;
	logic [7:0]  lcd_byte;
	logic        lcd_rs_in;
	logic [31:0] hex_value;

	// bus slave in place of the processor
	board_regs regs (
		.clock(clock), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.key_code(key_code), .key_valid(key_valid), .frame_error(frame_error),
		.lcd_busy(lcd_busy), .lcd_req(lcd_req), .lcd_byte(lcd_byte),
		.lcd_rs_in(lcd_rs_in), .lcd_on(lcd_on), .lcd_blon(lcd_blon),
		.leds(leds), .hex_value(hex_value)
	);

	// keyboard
	ps2_receiver keyboard (
		.clock(clock), .rst_n(rst_n),
		.ps2_clock(ps2_clock), .ps2_data(ps2_data),
		.key_code(key_code), .key_valid(key_valid), .frame_error(frame_error)
	);

	lcd_writer lcd (
		.clock(clock), .rst_n(rst_n),
		.lcd_req(lcd_req), .lcd_byte(lcd_byte), .lcd_rs_in(lcd_rs_in),
		.lcd_busy(lcd_busy), .lcd_data(lcd_data), .lcd_rs(lcd_rs),
		.lcd_rw(lcd_rw), .lcd_en(lcd_en)
	);

	hex_display digits (
		.hex_value(hex_value),
		.seg1(seg1), .seg2(seg2), .seg3(seg3), .seg4(seg4),
		.seg5(seg5), .seg6(seg6), .seg7(seg7), .seg8(seg8)
	);

endmodule

//--- verif/board_tb.sv
`include "board_consts.svh"

module board_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 20000;
	localparam logic [`AXI_ADDR_W-1:0] REG_NONE = 5'h14;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic clock = 1'b0;
	logic rst_n;
	logic [`AXI_ADDR_W-1:0] awaddr, araddr;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [`AXI_DATA_W-1:0] wdata, rdata;
	logic [`AXI_DATA_W/8-1:0] wstrb;
	logic [1:0] bresp, rresp;
	logic ps2_clock, ps2_data;
	logic [7:0] leds, lcd_data;
	logic lcd_rw, lcd_en, lcd_rs, lcd_on, lcd_blon;
	logic [6:0] seg1, seg2, seg3, seg4, seg5, seg6, seg7, seg8;

	int cycles = 0;
	logic [7:0] leds_at_resp;
	int en_cycles, en_pulses, en_faults;
	logic en_prev = 1'b0;
	logic [7:0] en_data;
	logic en_rs;

	board_top DUT (.*);

	always #2 clock = ~clock;

	always @(posedge clock) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** TEST FAILED ***");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// watches the lcd enable pulse, its width and the bus under it
	always @(negedge clock) begin
		if (lcd_en === 1'b1 && !en_prev) begin
			en_pulses++;
			en_data = lcd_data;
			en_rs = lcd_rs;
		end
		if (lcd_en === 1'b1) begin
			en_cycles++;
			if (lcd_data !== en_data || lcd_rs !== en_rs || lcd_rw !== 1'b0)
				en_faults++;
		end
		en_prev = (lcd_en === 1'b1);
	end

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH %s: actual 0x%h expected 0x%h", name, actual, expected);
			$display("*** TEST FAILED ***");
			$fatal(1, "stopping at the first error");
		end
	endtask

	// lit segments of the standard hex font with bit0 as segment a
	function automatic logic [6:0] font(input logic [3:0] nibble);
		logic [6:0] lit;
		case (nibble)
			4'h0: lit = 7'b0111111;
			4'h1: lit = 7'b0000110;
			4'h2: lit = 7'b1011011;
			4'h3: lit = 7'b1001111;
			4'h4: lit = 7'b1100110;
			4'h5: lit = 7'b1101101;
			4'h6: lit = 7'b1111101;
			4'h7: lit = 7'b0000111;
			4'h8: lit = 7'b1111111;
			4'h9: lit = 7'b1101111;
			4'hA: lit = 7'b1110111;
			4'hB: lit = 7'b1111100;
			4'hC: lit = 7'b0111001;
			4'hD: lit = 7'b1011110;
			4'hE: lit = 7'b1111001;
			default: lit = 7'b1110001;
		endcase
		// pins are active low
		return ~lit;
	endfunction

	function automatic logic [31:0] key_word(input logic ferr, input logic ovr,
			input logic new_key, input logic [7:0] code);
		return {21'b0, ferr, ovr, new_key, code};
	endfunction

	task automatic digits_show(input logic [31:0] value);
		check("seg1", seg1, font(value[3:0]));
		check("seg2", seg2, font(value[7:4]));
		check("seg3", seg3, font(value[11:8]));
		check("seg4", seg4, font(value[15:12]));
		check("seg5", seg5, font(value[19:16]));
		check("seg6", seg6, font(value[23:20]));
		check("seg7", seg7, font(value[27:24]));
		check("seg8", seg8, font(value[31:28]));
	endtask

	task automatic axi_write(input logic [`AXI_ADDR_W-1:0] addr, input logic [31:0] data,
			input int stall, output logic [1:0] resp);
		@(posedge clock);
		awaddr <= addr;
		wdata <= data;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		bready <= 1'b0;
		@(negedge clock);
		while (!awready) @(negedge clock);
		@(posedge clock);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		@(negedge clock);
		while (!bvalid) @(negedge clock);
		leds_at_resp = leds;
		repeat (stall) begin
			@(negedge clock);
			check("bvalid", bvalid, 1'b1);
		end
		resp = bresp;
		@(posedge clock);
		bready <= 1'b1;
		@(posedge clock);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [`AXI_ADDR_W-1:0] addr, input int stall,
			output logic [31:0] data, output logic [1:0] resp);
		@(posedge clock);
		araddr <= addr;
		arvalid <= 1'b1;
		rready <= 1'b0;
		@(negedge clock);
		while (!arready) @(negedge clock);
		@(posedge clock);
		arvalid <= 1'b0;
		@(negedge clock);
		while (!rvalid) @(negedge clock);
		repeat (stall) begin
			@(negedge clock);
			check("rvalid", rvalid, 1'b1);
		end
		data = rdata;
		resp = rresp;
		@(posedge clock);
		rready <= 1'b1;
		@(posedge clock);
		rready <= 1'b0;
	endtask

	task automatic read_expect(input logic [`AXI_ADDR_W-1:0] addr, input logic [31:0] expected,
			input string name);
		logic [31:0] data;
		logic [1:0] resp;
		axi_read(addr, 0, data, resp);
		check({name, " rresp"}, resp, RESP_OKAY);
		check(name, data, expected);
	endtask

	// data changes while the device holds the clock high
	task automatic ps2_send(input logic [7:0] code, input logic bad_parity);
		logic [10:0] bits;
		bits = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			@(posedge clock);
			ps2_data <= bits[i];
			repeat (10) @(posedge clock);
			ps2_clock <= 1'b0;
			repeat (20) @(posedge clock);
			ps2_clock <= 1'b1;
			repeat (10) @(posedge clock);
		end
	endtask

	task automatic registers_and_digits(output logic [31:0] hex_val);
		logic [7:0] led_val;
		logic [1:0] resp;
		led_val = 8'($urandom);
		hex_val = $urandom;
		@(negedge clock);
		check("awready", awready, 1'b1);
		check("wready", wready, 1'b1);
		check("arready", arready, 1'b1);
		check("bvalid", bvalid, 1'b0);
		check("rvalid", rvalid, 1'b0);
		read_expect(`REG_CTRL, 0, "ctrl");
		read_expect(`REG_LEDS, 0, "leds reg");
		read_expect(`REG_HEX, 0, "hex reg");
		read_expect(`REG_LCD, 0, "lcd reg");
		read_expect(`REG_KEY, 0, "key reg");
		check("leds", leds, 0);
		check("lcd_on", lcd_on, 0);
		check("lcd_blon", lcd_blon, 0);
		check("lcd_en", lcd_en, 0);
		digits_show(0);
		axi_write(`REG_LEDS, {24'b0, led_val}, 0, resp);
		check("leds bresp", resp, RESP_OKAY);
		check("leds at bvalid", leds_at_resp, led_val);
		check("leds", leds, led_val);
		read_expect(`REG_LEDS, led_val, "leds reg");
		axi_write(`REG_HEX, hex_val, 0, resp);
		digits_show(hex_val);
		read_expect(`REG_HEX, hex_val, "hex reg");
		axi_write(`REG_CTRL, 32'h3, 0, resp);
		check("lcd_on", lcd_on, 1'b1);
		check("lcd_blon", lcd_blon, 1'b1);
		read_expect(`REG_CTRL, 32'h3, "ctrl");
	endtask

	task automatic key_reception(input logic [31:0] hex_val, output logic [7:0] code);
		logic [1:0] resp;
		// scancode differs from the low byte of HEX so the swap shows
		code = hex_val[7:0] ^ (8'($urandom % 255) + 8'd1);
		ps2_send(code, 1'b0);
		read_expect(`REG_KEY, key_word(0, 0, 1, code), "key reg");
		read_expect(`REG_KEY, key_word(0, 0, 0, code), "key reg");
		axi_write(`REG_CTRL, 32'h7, 0, resp);
		digits_show({hex_val[31:8], code});
		axi_write(`REG_CTRL, 32'h3, 0, resp);
		digits_show(hex_val);
	endtask

	task automatic key_errors(input logic [7:0] old_code);
		logic [7:0] code_a;
		logic [7:0] code_b;
		// each code differs from the one before it
		code_a = old_code ^ (8'($urandom % 255) + 8'd1);
		code_b = code_a ^ (8'($urandom % 255) + 8'd1);
		ps2_send(code_a, 1'b1);
		read_expect(`REG_KEY, key_word(1, 0, 0, old_code), "key reg");
		ps2_send(code_a, 1'b0);
		ps2_send(code_b, 1'b0);
		ps2_send(code_a, 1'b1);
		read_expect(`REG_KEY, key_word(1, 1, 1, code_b), "key reg");
		read_expect(`REG_KEY, key_word(0, 0, 0, code_b), "key reg");
	endtask

	task automatic lcd_sequence();
		logic [7:0] byte_val;
		logic [31:0] data;
		logic [1:0] resp;
		byte_val = 8'($urandom);
		en_cycles = 0;
		en_pulses = 0;
		en_faults = 0;
		axi_write(`REG_LCD, {23'b0, 1'b1, byte_val}, 0, resp);
		check("lcd bresp", resp, RESP_OKAY);
		read_expect(`REG_LCD, 32'h1, "lcd busy");
		axi_write(`REG_LCD, {23'b0, 1'b0, ~byte_val}, 0, resp);
		check("lcd busy bresp", resp, RESP_SLVERR);
		do
			axi_read(`REG_LCD, 0, data, resp);
		while (data[0]);
		repeat (30) @(posedge clock);
		check("lcd_en pulses", en_pulses, 1);
		check("lcd_en width", en_cycles, `LCD_EN_CYCLES);
		check("lcd_data", en_data, byte_val);
		check("lcd_rs", en_rs, 1'b1);
		check("lcd bus changes under lcd_en", en_faults, 0);
		check("lcd_rw", lcd_rw, 1'b0);
	endtask

	task automatic bus_errors();
		logic [7:0] led_val;
		logic [31:0] data;
		logic [1:0] resp;
		led_val = 8'($urandom);
		axi_write(REG_NONE, 32'h1234, 0, resp);
		check("unmapped bresp", resp, RESP_SLVERR);
		axi_read(REG_NONE, 0, data, resp);
		check("unmapped rresp", resp, RESP_SLVERR);
		check("unmapped rdata", data, 0);
		axi_write(`REG_KEY, 32'hFF, 0, resp);
		check("key write bresp", resp, RESP_SLVERR);
		axi_write(`REG_LEDS, {24'b0, led_val}, 10, resp);
		check("stalled bresp", resp, RESP_OKAY);
		check("leds", leds, led_val);
		axi_read(`REG_LEDS, 10, data, resp);
		check("stalled rresp", resp, RESP_OKAY);
		check("stalled rdata", data, led_val);
	endtask

	initial begin
		logic [31:0] hex_shown;
		logic [7:0] first_code;
		void'($urandom(22040));
		rst_n <= 1'b0;
		awaddr <= '0;
		awvalid <= 1'b0;
		wdata <= '0;
		wstrb <= 4'hF;
		wvalid <= 1'b0;
		bready <= 1'b0;
		araddr <= '0;
		arvalid <= 1'b0;
		rready <= 1'b0;
		ps2_clock <= 1'b1;
		ps2_data <= 1'b1;
		repeat (8) @(posedge clock);
		rst_n <= 1'b1;
		repeat (2) @(posedge clock);
		registers_and_digits(hex_shown);
		key_reception(hex_shown, first_code);
		key_errors(first_code);
		lcd_sequence();
		bus_errors();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+common
common/board_pkg.sv
ps2/ps2_receiver.sv
lcd/lcd_writer.sv
verilog/hex_display.sv
verilog/board_regs.sv
verilog/board_top.sv
verif/board_tb.sv
